//--- icache_bypass_pkg.sv
/*
 * Instruction cache bypass fetch path, shared definitions.
 * Widths, port count, order FIFO depth, vector types and the
 * per-port fetch state encoding.
 */
`default_nettype none

package icache_bypass_pkg;

  localparam int NR_FETCH_PORTS = 2;
  localparam int FETCH_AW       = 32;
  localparam int FETCH_DW       = 32;
  localparam int LINE_WIDTH     = 128;
  localparam int FETCH_ALIGN    = 2;
  localparam int LINE_ALIGN     = 4;
  localparam int ORDER_DEPTH    = 4;

  // Derived index widths
  localparam int PORT_IW  = $clog2(NR_FETCH_PORTS);
  localparam int ORDER_PW = $clog2(ORDER_DEPTH);
  localparam int WORD_SW  = LINE_ALIGN - FETCH_ALIGN;

  typedef logic [FETCH_AW-1:0]       fetch_addr_t;
  typedef logic [FETCH_DW-1:0]       fetch_data_t;
  typedef logic [LINE_WIDTH-1:0]     line_data_t;
  typedef logic [NR_FETCH_PORTS-1:0] port_mask_t;

  // One fetch from acceptance to its single presentation cycle
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RSP,
    PRESENT
  } port_state_e;

endpackage

`default_nettype wire

//--- bypass_port_ctrl.sv
/*
 * Bypass fetch port controller.
 * Accepts one fetch, requests a refill while order space is free,
 * waits for the steered response and presents it for one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module bypass_port_ctrl
  import icache_bypass_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic fetch_valid_i,
  input  logic order_full_i,
  input  logic grant_i,
  input  logic rsp_hit_i,
  output logic req_o,
  output logic fetch_ready_o
);

  port_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (fetch_valid_i) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        if (grant_i) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (rsp_hit_i) begin
          state_d = PRESENT;
        end
      end
      // The result sits in the steering register for exactly this cycle
      PRESENT: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Only ask while an owner slot is free, so every granted refill gets recorded
  assign req_o         = (state_q == REQUEST) && !order_full_i;
  assign fetch_ready_o = (state_q == PRESENT);

  // A steered response must belong to a refill this port is waiting on
  a_hit_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_hit_i |-> state_q == WAIT_RSP);

endmodule

`default_nettype wire

//--- bypass_req_arbiter.sv
/*
 * Round-robin refill request arbiter.
 * Aligns the winning address to a line and keeps the choice fixed
 * while the refill port stalls the request.
 */
`timescale 1ns/1ps
`default_nettype none

module bypass_req_arbiter
  import icache_bypass_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  port_mask_t                        req_i,
  input  fetch_addr_t [NR_FETCH_PORTS-1:0]  fetch_addr_i,
  output port_mask_t                        grant_o,
  output fetch_addr_t                       refill_req_addr_o,
  output logic                              refill_req_valid_o,
  input  logic                              refill_req_ready_i
);

  logic [PORT_IW-1:0] rr_q;
  logic [PORT_IW-1:0] lock_idx_q;
  logic [PORT_IW-1:0] pick;
  logic [PORT_IW-1:0] cand;
  logic [PORT_IW-1:0] sel;
  logic               lock_q;
  logic               found;
  logic               xfer;

  // Search from the round-robin pointer for the first requesting port
  always_comb begin
    pick  = rr_q;
    cand  = rr_q;
    found = 1'b0;
    for (int k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = PORT_IW'((int'(rr_q) + k) % NR_FETCH_PORTS);
      if (!found && req_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  assign sel                = lock_q ? lock_idx_q : pick;
  assign refill_req_valid_o = lock_q ? req_i[lock_idx_q] : found;
  assign refill_req_addr_o  = {fetch_addr_i[sel][FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign xfer               = refill_req_valid_o && refill_req_ready_i;

  always_comb begin
    grant_o = '0;
    if (xfer) begin
      grant_o[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      lock_q <= 1'b0;
      rr_q   <= (sel == PORT_IW'(NR_FETCH_PORTS - 1)) ? '0 : sel + 1'b1;
    end else if (refill_req_valid_o) begin
      // Stalled, so hold this port until the refill port takes it
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end
  end

  // Relies on the requester holding its address until the fetch completes
  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    refill_req_valid_o && !refill_req_ready_i
      |=> refill_req_valid_o && $stable(refill_req_addr_o));

endmodule

`default_nettype wire

//--- bypass_order_fifo.sv
/*
 * Refill order FIFO.
 * Holds the one-hot owner mask of every outstanding refill in
 * request order, so responses can be steered back.
 */
`timescale 1ns/1ps
`default_nettype none

module bypass_order_fifo
  import icache_bypass_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  port_mask_t push_mask_i,
  input  logic       pop_i,
  output port_mask_t head_mask_o,
  output logic       full_o,
  output logic       empty_o
);

  port_mask_t          mem_q [ORDER_DEPTH];
  logic [ORDER_PW-1:0] wptr_q;
  logic [ORDER_PW-1:0] rptr_q;
  logic [ORDER_PW:0]   count_q;
  logic                push;

  // Any granted port is an outstanding refill
  assign push = |push_mask_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= push_mask_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q <= rptr_q + 1'b1;
      end
      unique case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_mask_o = mem_q[rptr_q];
  assign full_o      = (count_q == (ORDER_PW + 1)'(ORDER_DEPTH));
  assign empty_o     = (count_q == '0);

  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push |-> !full_o);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- bypass_rsp_steer.sv
/*
 * Refill response steering.
 * Routes each refill line to the port at the head of the order FIFO
 * and registers the addressed word and its error flag for that port.
 */
`timescale 1ns/1ps
`default_nettype none

module bypass_rsp_steer
  import icache_bypass_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  port_mask_t                        head_mask_i,
  input  logic                              order_empty_i,
  input  fetch_addr_t [NR_FETCH_PORTS-1:0]  fetch_addr_i,
  input  line_data_t                        refill_rsp_data_i,
  input  logic                              refill_rsp_error_i,
  input  logic                              refill_rsp_valid_i,
  output logic                              refill_rsp_ready_o,
  output logic                              pop_o,
  output port_mask_t                        rsp_hit_o,
  output fetch_data_t [NR_FETCH_PORTS-1:0]  inst_data_o,
  output port_mask_t                        inst_error_o
);

  logic [WORD_SW-1:0] word_sel [NR_FETCH_PORTS];
  logic               xfer;

  // A response can only be taken when its owner is known
  assign refill_rsp_ready_o = !order_empty_i;
  assign xfer               = refill_rsp_valid_i && refill_rsp_ready_o;
  assign pop_o              = xfer;
  assign rsp_hit_o          = xfer ? head_mask_i : '0;

  always_comb begin
    for (int p = 0; p < NR_FETCH_PORTS; p++) begin
      word_sel[p] = fetch_addr_i[p][LINE_ALIGN-1:FETCH_ALIGN];
    end
  end

  // Each port keeps its last result until the next hit overwrites it
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NR_FETCH_PORTS; p++) begin
      if (rsp_hit_o[p]) begin
        inst_data_o[p]  <= refill_rsp_data_i[word_sel[p]*FETCH_DW +: FETCH_DW];
        inst_error_o[p] <= refill_rsp_error_i;
      end
    end
  end

  // Every recorded owner came from a one-hot arbiter grant
  a_head_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    !order_empty_i |-> $onehot(head_mask_i));

endmodule

`default_nettype wire

//--- icache_bypass.sv
/*
 * Uncached instruction fetch path, top level.
 * Per-port controllers and a round-robin arbiter issue line refills,
 * an order FIFO records owners and the steering returns the words.
 */
`timescale 1ns/1ps
`default_nettype none

module icache_bypass
  import icache_bypass_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  fetch_addr_t [NR_FETCH_PORTS-1:0]  inst_addr_i,
  input  port_mask_t                        inst_valid_i,
  output port_mask_t                        inst_ready_o,
  output fetch_data_t [NR_FETCH_PORTS-1:0]  inst_data_o,
  output port_mask_t                        inst_error_o,

  output fetch_addr_t                       refill_req_addr_o,
  output logic                              refill_req_valid_o,
  input  logic                              refill_req_ready_i,

  input  line_data_t                        refill_rsp_data_i,
  input  logic                              refill_rsp_error_i,
  input  logic                              refill_rsp_valid_i,
  output logic                              refill_rsp_ready_o
);

  port_mask_t req;
  port_mask_t grant;
  port_mask_t rsp_hit;
  port_mask_t head_mask;
  logic       order_full;
  logic       order_empty;
  logic       pop;

  for (genvar p = 0; p < NR_FETCH_PORTS; p++) begin : gen_port
    bypass_port_ctrl u_port_ctrl (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .fetch_valid_i (inst_valid_i[p]),
      .order_full_i  (order_full),
      .grant_i       (grant[p]),
      .rsp_hit_i     (rsp_hit[p]),
      .req_o         (req[p]),
      .fetch_ready_o (inst_ready_o[p])
    );
  end

  bypass_req_arbiter u_req_arbiter (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .req_i              (req),
    .fetch_addr_i       (inst_addr_i),
    .grant_o            (grant),
    .refill_req_addr_o  (refill_req_addr_o),
    .refill_req_valid_o (refill_req_valid_o),
    .refill_req_ready_i (refill_req_ready_i)
  );

  // The grant of an accepted refill doubles as its owner record
  bypass_order_fifo u_order_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_mask_i (grant),
    .pop_i       (pop),
    .head_mask_o (head_mask),
    .full_o      (order_full),
    .empty_o     (order_empty)
  );

  bypass_rsp_steer u_rsp_steer (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .head_mask_i        (head_mask),
    .order_empty_i      (order_empty),
    .fetch_addr_i       (inst_addr_i),
    .refill_rsp_data_i  (refill_rsp_data_i),
    .refill_rsp_error_i (refill_rsp_error_i),
    .refill_rsp_valid_i (refill_rsp_valid_i),
    .refill_rsp_ready_o (refill_rsp_ready_o),
    .pop_o              (pop),
    .rsp_hit_o          (rsp_hit),
    .inst_data_o        (inst_data_o),
    .inst_error_o       (inst_error_o)
  );

endmodule

`default_nettype wire

//--- tb_icache_bypass.sv
/*
 * Testbench for the bypass instruction fetch path.
 * Random fetches on both ports run against a refill memory model,
 * and every returned word is checked against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_icache_bypass
  import icache_bypass_pkg::*;
();

  localparam int N_SINGLE    = 50;
  localparam int N_DUAL      = 100;
  localparam int N_STALL     = 40;
  localparam int N_DEEP      = 40;
  localparam int CYCLE_LIMIT = 60 * (N_SINGLE + 2 * N_DUAL + 2 * N_STALL + 2 * N_DEEP);
  localparam int MEM_RANDOM  = 0;
  localparam int MEM_STALL   = 1;
  localparam int MEM_DEEP    = 2;

  logic                             clk = 1'b0;
  logic                             reset = 1'b1;
  fetch_addr_t [NR_FETCH_PORTS-1:0] inst_addr = '0;
  port_mask_t                       inst_valid = '0;
  port_mask_t                       inst_ready;
  fetch_data_t [NR_FETCH_PORTS-1:0] inst_data;
  port_mask_t                       inst_error;
  fetch_addr_t                      refill_req_addr;
  logic                             refill_req_valid;
  logic                             refill_req_ready = 1'b0;
  line_data_t                       refill_rsp_data = '0;
  logic                             refill_rsp_error = 1'b0;
  logic                             refill_rsp_valid = 1'b0;
  logic                             refill_rsp_ready;

  integer      seed = 34;
  int          errors = 0;
  int          cycles = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          mem_mode = MEM_RANDOM;
  int          gap_max = 0;
  logic        single_port = 1'b0;
  int          target [NR_FETCH_PORTS];
  int          issued [NR_FETCH_PORTS];
  int          done [NR_FETCH_PORTS];
  int          gap_left [NR_FETCH_PORTS];
  logic        busy [NR_FETCH_PORTS];
  fetch_addr_t pending_q [$];
  int          rsp_delay;
  int          stall_left;
  logic        rsp_active;
  logic        prev_stall;
  fetch_addr_t prev_addr;

  icache_bypass u_icache_bypass (
    .clk_i              (clk),
    .reset_i            (reset),
    .inst_addr_i        (inst_addr),
    .inst_valid_i       (inst_valid),
    .inst_ready_o       (inst_ready),
    .inst_data_o        (inst_data),
    .inst_error_o       (inst_error),
    .refill_req_addr_o  (refill_req_addr),
    .refill_req_valid_o (refill_req_valid),
    .refill_req_ready_i (refill_req_ready),
    .refill_rsp_data_i  (refill_rsp_data),
    .refill_rsp_error_i (refill_rsp_error),
    .refill_rsp_valid_i (refill_rsp_valid),
    .refill_rsp_ready_o (refill_rsp_ready)
  );

  always #20 clk = ~clk;

  // Word k of the line at A holds (A + 4k) xor A5A50000
  function automatic fetch_data_t line_word(input fetch_addr_t line_addr, input int k);
    return (line_addr + FETCH_AW'(4 * k)) ^ 32'hA5A5_0000;
  endfunction

  function automatic fetch_addr_t line_base(input fetch_addr_t addr);
    fetch_addr_t base;
    base                 = addr;
    base[LINE_ALIGN-1:0] = '0;
    return base;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Fetch requesters, refill memory and reference checks
  always @(posedge clk) begin
    fetch_addr_t addr;
    line_data_t  line_data;
    logic        any_busy;
    if (reset) begin
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        issued[p]   = 0;
        done[p]     = 0;
        gap_left[p] = 0;
        busy[p]     = 1'b0;
      end
      rsp_delay  = 0;
      stall_left = 0;
      rsp_active = 1'b0;
      prev_stall = 1'b0;
      prev_addr  = '0;
    end else begin
      any_busy = 1'b0;
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        any_busy = any_busy | busy[p];
      end
      if (!any_busy) begin
        check_value(32'(inst_ready), 32'd0, "fetch ready with no fetch active");
        check_value(32'(refill_req_valid), 32'd0, "refill request with no fetch active");
      end
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        if (inst_ready[p] && !busy[p]) begin
          errors++;
          $display("Port %0d signalled ready at %0t ns without an open fetch", p, $time);
        end else if (inst_ready[p]) begin
          addr = inst_addr[p];
          check_value(inst_data[p], line_word(line_base(addr), int'(addr[3:2])),
                      $sformatf("port %0d word for %h", p, addr));
          check_value(32'(inst_error[p]), 32'(addr[12]), $sformatf("port %0d error for %h", p, addr));
          done[p]++;
          busy[p]       = 1'b0;
          inst_valid[p] <= 1'b0;
        end
        if (!busy[p] && issued[p] < target[p]) begin
          if (gap_left[p] > 0) begin
            gap_left[p]--;
          end else begin
            addr                  = $random(seed);
            addr[FETCH_ALIGN-1:0] = '0;
            inst_addr[p]  <= addr;
            inst_valid[p] <= 1'b1;
            busy[p]       = 1'b1;
            issued[p]++;
            gap_left[p] = {$random(seed)} % (gap_max + 1);
          end
        end
      end

      // A stalled request keeps both its valid and its address
      if (prev_stall) begin
        check_value(32'(refill_req_valid), 32'd1, "refill request dropped while stalled");
        check_value(refill_req_addr, prev_addr, "refill address changed while stalled");
      end
      prev_stall = refill_req_valid && !refill_req_ready;
      prev_addr  = refill_req_addr;

      // Responses are taken exactly while some accepted refill is unanswered
      check_value(32'(refill_rsp_ready), 32'(pending_q.size() > 0), "refill response ready");

      if (refill_rsp_valid && refill_rsp_ready) begin
        void'(pending_q.pop_front());
        refill_rsp_valid <= 1'b0;
        rsp_active = 1'b0;
        rsp_delay  = (mem_mode == MEM_DEEP) ? 5 : int'({$random(seed)} % 6);
      end
      if (refill_req_valid && refill_req_ready) begin
        if (single_port) begin
          check_value(refill_req_addr, line_base(inst_addr[0]), "refill address");
        end
        pending_q.push_back(refill_req_addr);
        if (pending_q.size() > ORDER_DEPTH) begin
          errors++;
          $display("Too many refills in flight at %0t ns: %0d", $time, pending_q.size());
        end
      end
      if (!rsp_active && pending_q.size() > 0) begin
        if (rsp_delay > 0) begin
          rsp_delay--;
        end else begin
          for (int k = 0; k < LINE_WIDTH / FETCH_DW; k++) begin
            line_data[k*FETCH_DW +: FETCH_DW] = line_word(pending_q[0], k);
          end
          refill_rsp_data  <= line_data;
          refill_rsp_error <= pending_q[0][12];
          refill_rsp_valid <= 1'b1;
          rsp_active = 1'b1;
        end
      end

      case (mem_mode)
        MEM_STALL: begin
          if (stall_left > 0) begin
            refill_req_ready <= 1'b0;
            stall_left--;
          end else begin
            refill_req_ready <= 1'b1;
            if ({$random(seed)} % 4 == 0) begin
              stall_left = 1 + int'({$random(seed)} % 8);
            end
          end
        end
        MEM_DEEP: refill_req_ready <= 1'b1;
        default:  refill_req_ready <= ({$random(seed)} % 4) != 0;
      endcase
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, fetches are still outstanding", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic run_test(input string name, input int n0, input int n1, input int gap,
                          input int mode);
    int errors_before;
    errors_before = errors;
    @(negedge clk);
    single_port = (n1 == 0);
    gap_max     = gap;
    mem_mode    = mode;
    target[0]   = done[0] + n0;
    target[1]   = done[1] + n1;
    while (done[0] < target[0] || done[1] < target[1]) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  initial begin
    target[0] = 0;
    target[1] = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    run_test("idle after reset", 0, 0, 0, MEM_RANDOM);
    run_test("single port", N_SINGLE, 0, 2, MEM_RANDOM);
    run_test("both ports", N_DUAL, N_DUAL, 3, MEM_RANDOM);
    run_test("refill back-pressure", N_STALL, N_STALL, 1, MEM_STALL);
    run_test("deep outstanding", N_DEEP, N_DEEP, 0, MEM_DEEP);
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
icache_bypass_pkg.sv
bypass_port_ctrl.sv
bypass_req_arbiter.sv
bypass_order_fifo.sv
bypass_rsp_steer.sv
icache_bypass.sv
tb_icache_bypass.sv

//--- run_sim.sh
#!/bin/sh
# Build the bypass fetch path and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_icache_bypass \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
